// File: build.f
logic/rv_core_pkg.sv
logic/rv_stage_if.sv
logic/register_file.sv
logic/hazard_control.sv
logic/fetch_decode.sv
logic/execute_unit.sv
logic/memory_writeback.sv
logic/rv_core_top.sv
tests/rv_core_tb.sv

// File: logic/execute_unit.sv
module execute_unit
(
    input  logic               clk,
    input  logic               reset,
    decoded_if.sink            decoded,
    output rv_core_pkg::word_t ex_result,
    output logic               redirect,
    output rv_core_pkg::word_t redirect_target,
    retire_if.source           retired
);

    rv_core_pkg::word_t operand_a, operand_b, alu_out, address_base, address_sum, address;
    logic [4:0] shamt;
    logic taken;

    assign operand_a = decoded.rs1_value;
    assign operand_b = decoded.use_immediate ? decoded.immediate : decoded.rs2_value;
    assign shamt = operand_b[4:0];

    // --------------------
    // ALU
    // --------------------
    always_comb
    begin
        case (decoded.alu_op)
            rv_core_pkg::alu_sub:  alu_out = operand_a - operand_b;
            rv_core_pkg::alu_sll:  alu_out = operand_a << shamt;
            rv_core_pkg::alu_slt:  alu_out = rv_core_pkg::word_t'($signed(operand_a) < $signed(operand_b));
            rv_core_pkg::alu_sltu: alu_out = rv_core_pkg::word_t'(operand_a < operand_b);
            rv_core_pkg::alu_xor:  alu_out = operand_a ^ operand_b;
            rv_core_pkg::alu_srl:  alu_out = operand_a >> shamt;
            rv_core_pkg::alu_sra:  alu_out = $signed(operand_a) >>> shamt;
            rv_core_pkg::alu_or:   alu_out = operand_a | operand_b;
            rv_core_pkg::alu_and:  alu_out = operand_a & operand_b;
            default:               alu_out = operand_a + operand_b;
        endcase
    end

    // Address generator
    // JALR, loads and stores add to rs1, everything else is PC relative
    assign address_base = decoded.use_immediate ? decoded.rs1_value : decoded.pc;
    assign address_sum = address_base + decoded.immediate;
    assign address = (decoded.instr_class == rv_core_pkg::class_jump_link)
                   ? {address_sum[31:1], 1'b0} : address_sum;

    // Branch comparator
    always_comb
    begin
        case (decoded.branch_funct3)
            rv_core_pkg::funct3_beq:  taken = decoded.rs1_value == decoded.rs2_value;
            rv_core_pkg::funct3_bne:  taken = decoded.rs1_value != decoded.rs2_value;
            rv_core_pkg::funct3_blt:  taken = $signed(decoded.rs1_value) < $signed(decoded.rs2_value);
            rv_core_pkg::funct3_bge:  taken = $signed(decoded.rs1_value) >= $signed(decoded.rs2_value);
            rv_core_pkg::funct3_bltu: taken = decoded.rs1_value < decoded.rs2_value;
            rv_core_pkg::funct3_bgeu: taken = decoded.rs1_value >= decoded.rs2_value;
            default:                  taken = 1'b0;
        endcase
    end

    assign redirect = (decoded.instr_class == rv_core_pkg::class_jump_link)
                   || (decoded.instr_class == rv_core_pkg::class_branch && taken);
    assign redirect_target = address;

    // Value forwarded to FD, loads and stores carry their address
    always_comb
    begin
        case (decoded.instr_class)
            rv_core_pkg::class_lui:       ex_result = decoded.immediate;
            rv_core_pkg::class_jump_link: ex_result = decoded.link_pc;
            rv_core_pkg::class_auipc,
            rv_core_pkg::class_load,
            rv_core_pkg::class_store:     ex_result = address;
            default:                      ex_result = alu_out;
        endcase
    end

    // --------------------
    // EX to MW register
    // --------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            retired.instr_class <= rv_core_pkg::class_bubble;
            retired.rd_write <= 1'b0;
        end
        else
        begin
            retired.instr_class <= decoded.instr_class;
            retired.rd_write <= decoded.rd_write;
        end
    end

    always_ff @(posedge clk)
    begin
        retired.rd_index <= decoded.rd_index;
        retired.result <= ex_result;
        retired.address <= address;
        retired.store_data <= decoded.rs2_value;
    end

endmodule

// File: logic/fetch_decode.sv
module fetch_decode
(
    input  logic                      clk,
    input  logic                      reset,
    output logic                      instr_enable,
    output rv_core_pkg::word_t        instr_address,
    input  rv_core_pkg::word_t        instr_data,
    input  logic                      stall,
    input  logic                      redirect,
    input  rv_core_pkg::word_t        redirect_target,
    input  rv_core_pkg::forward_sel_e forward_sel_1,
    input  rv_core_pkg::forward_sel_e forward_sel_2,
    input  rv_core_pkg::word_t        ex_result,
    input  rv_core_pkg::word_t        wb_data,
    output rv_core_pkg::reg_index_t   rs1_index,
    output rv_core_pkg::reg_index_t   rs2_index,
    output logic                      rs1_used,
    output logic                      rs2_used,
    input  rv_core_pkg::word_t        rf_data_1,
    input  rv_core_pkg::word_t        rf_data_2,
    decoded_if.source                 decoded
);

    rv_core_pkg::word_t pc, word, immediate, rs1_value, rs2_value;
    rv_core_pkg::instr_class_e instr_class;
    rv_core_pkg::alu_op_e alu_op;
    logic use_immediate, writes_rd;
    logic [2:0] funct3;

    // funct3 to ALU operation, alt is instruction bit 30 where it matters
    function automatic rv_core_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            rv_core_pkg::funct3_add:  return alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
            rv_core_pkg::funct3_sll:  return rv_core_pkg::alu_sll;
            rv_core_pkg::funct3_slt:  return rv_core_pkg::alu_slt;
            rv_core_pkg::funct3_sltu: return rv_core_pkg::alu_sltu;
            rv_core_pkg::funct3_xor:  return rv_core_pkg::alu_xor;
            rv_core_pkg::funct3_srl:  return alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
            rv_core_pkg::funct3_or:   return rv_core_pkg::alu_or;
            default:                  return rv_core_pkg::alu_and;
        endcase
    endfunction

    // --------------------
    // Fetch
    // --------------------
    // Redirect wins over a load-use hold
    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= rv_core_pkg::reset_address;
        else if (redirect)
            pc <= redirect_target;
        else if (!stall)
            pc <= pc + 32'd4;
    end

    assign instr_enable = !reset;
    assign instr_address = pc;

    // Bus contents are meaningless while fetch is off
    assign word = instr_enable ? instr_data : rv_core_pkg::nop_word;
    assign funct3 = word[14:12];
    assign rs1_index = word[19:15];
    assign rs2_index = word[24:20];

    // --------------------
    // Decode
    // --------------------
    always_comb
    begin
        instr_class = rv_core_pkg::class_bubble;
        alu_op = rv_core_pkg::alu_add;
        use_immediate = 1'b0;
        immediate = '0;
        writes_rd = 1'b0;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        case (word[6:0])
            rv_core_pkg::opcode_op:
            begin
                instr_class = rv_core_pkg::class_alu;
                alu_op = alu_decode(funct3, word[30]);
                writes_rd = 1'b1;
                rs1_used = 1'b1;
                rs2_used = 1'b1;
            end
            rv_core_pkg::opcode_op_imm:
            begin
                // Only shifts look at bit 30, there is no SUBI
                instr_class = rv_core_pkg::class_alu;
                alu_op = alu_decode(funct3, word[30] && funct3 == rv_core_pkg::funct3_srl);
                use_immediate = 1'b1;
                immediate = {{20{word[31]}}, word[31:20]};
                writes_rd = 1'b1;
                rs1_used = 1'b1;
            end
            rv_core_pkg::opcode_lui, rv_core_pkg::opcode_auipc:
            begin
                instr_class = (word[5]) ? rv_core_pkg::class_lui : rv_core_pkg::class_auipc;
                immediate = {word[31:12], 12'b0};
                writes_rd = 1'b1;
            end
            rv_core_pkg::opcode_jal:
            begin
                instr_class = rv_core_pkg::class_jump_link;
                immediate = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
                writes_rd = 1'b1;
            end
            rv_core_pkg::opcode_jalr:
            begin
                instr_class = rv_core_pkg::class_jump_link;
                use_immediate = 1'b1;
                immediate = {{20{word[31]}}, word[31:20]};
                writes_rd = 1'b1;
                rs1_used = 1'b1;
            end
            rv_core_pkg::opcode_branch:
            begin
                instr_class = rv_core_pkg::class_branch;
                immediate = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
                rs1_used = 1'b1;
                rs2_used = 1'b1;
            end
            rv_core_pkg::opcode_load:
            begin
                instr_class = rv_core_pkg::class_load;
                use_immediate = 1'b1;
                immediate = {{20{word[31]}}, word[31:20]};
                writes_rd = 1'b1;
                rs1_used = 1'b1;
            end
            rv_core_pkg::opcode_store:
            begin
                instr_class = rv_core_pkg::class_store;
                use_immediate = 1'b1;
                immediate = {{20{word[31]}}, word[31:25], word[11:7]};
                rs1_used = 1'b1;
                rs2_used = 1'b1;
            end
            default:
            begin
                instr_class = rv_core_pkg::class_bubble;
            end
        endcase
    end

    // Operand sources, newest value first as chosen by hazard control
    always_comb
    begin
        case (forward_sel_1)
            rv_core_pkg::from_ex: rs1_value = ex_result;
            rv_core_pkg::from_mw: rs1_value = wb_data;
            default:              rs1_value = rf_data_1;
        endcase
        case (forward_sel_2)
            rv_core_pkg::from_ex: rs2_value = ex_result;
            rv_core_pkg::from_mw: rs2_value = wb_data;
            default:              rs2_value = rf_data_2;
        endcase
    end

    // --------------------
    // FD to EX register
    // --------------------
    always_ff @(posedge clk)
    begin
        if (reset || stall || redirect)
        begin
            decoded.instr_class <= rv_core_pkg::class_bubble;
            decoded.rd_write <= 1'b0;
        end
        else
        begin
            decoded.instr_class <= instr_class;
            // Writes to x0 are dropped here so later stages never see them
            decoded.rd_write <= writes_rd && (word[11:7] != '0);
        end
    end

    always_ff @(posedge clk)
    begin
        decoded.pc <= pc;
        decoded.link_pc <= pc + 32'd4;
        decoded.alu_op <= alu_op;
        decoded.use_immediate <= use_immediate;
        decoded.branch_funct3 <= funct3;
        decoded.rs1_value <= rs1_value;
        decoded.rs2_value <= rs2_value;
        decoded.immediate <= immediate;
        decoded.rd_index <= word[11:7];
    end

endmodule

// File: logic/hazard_control.sv
module hazard_control
(
    input  rv_core_pkg::reg_index_t   rs1_index,
    input  rv_core_pkg::reg_index_t   rs2_index,
    input  logic                      rs1_used,
    input  logic                      rs2_used,
    input  logic                      redirect,
    decoded_if.monitor                decoded,
    input  logic                      wb_write,
    input  rv_core_pkg::reg_index_t   wb_index,
    output logic                      stall,
    output rv_core_pkg::forward_sel_e forward_sel_1,
    output rv_core_pkg::forward_sel_e forward_sel_2
);

    logic load_in_ex, load_match;

    // EX holds the younger result, so it beats MW
    function automatic rv_core_pkg::forward_sel_e pick_source(
        input rv_core_pkg::reg_index_t index,
        input logic ex_write,
        input rv_core_pkg::reg_index_t ex_index,
        input logic mw_write,
        input rv_core_pkg::reg_index_t mw_index
    );
        if (index == '0)
            return rv_core_pkg::from_file;
        if (ex_write && ex_index == index)
            return rv_core_pkg::from_ex;
        if (mw_write && mw_index == index)
            return rv_core_pkg::from_mw;
        return rv_core_pkg::from_file;
    endfunction

    // Load data only exists in MW, one cycle too late for EX forwarding
    assign load_in_ex = decoded.instr_class == rv_core_pkg::class_load && decoded.rd_write;
    assign load_match = (rs1_used && rs1_index == decoded.rd_index)
                     || (rs2_used && rs2_index == decoded.rd_index);

    always_comb
    begin
        forward_sel_1 = pick_source(rs1_index, decoded.rd_write, decoded.rd_index,
                                    wb_write, wb_index);
        forward_sel_2 = pick_source(rs2_index, decoded.rd_write, decoded.rd_index,
                                    wb_write, wb_index);
        // FD is squashed on a redirect, so there is nothing to hold
        stall = load_in_ex && load_match && !redirect;

        // A load in EX never redirects
        assert (!(load_in_ex && load_match && redirect))
            else $error("load-use hazard seen together with a redirect from EX");
        // FD drops writes to x0 before EX
        assert (!(decoded.rd_write && decoded.rd_index == '0)
             && !(wb_write && wb_index == '0))
            else $error("pipeline announces a register write to x0");
    end

endmodule

// File: logic/memory_writeback.sv
module memory_writeback
(
    retire_if.sink                  retired,
    output logic                    data_read_enable,
    output logic                    data_write_enable,
    output rv_core_pkg::word_t      data_address,
    output rv_core_pkg::word_t      data_write_data,
    input  rv_core_pkg::word_t      data_read_data,
    output logic                    wb_write,
    output rv_core_pkg::reg_index_t wb_index,
    output rv_core_pkg::word_t      wb_data
);

    // Data memory access, word wide only
    assign data_read_enable = retired.instr_class == rv_core_pkg::class_load;
    assign data_write_enable = retired.instr_class == rv_core_pkg::class_store;
    assign data_address = retired.address;
    assign data_write_data = retired.store_data;

    // Writeback select
    // rd_write is already low for stores, branches and bubbles
    assign wb_write = retired.rd_write;
    assign wb_index = retired.rd_index;
    assign wb_data = data_read_enable ? data_read_data : retired.result;

    // FD clears rd_write for stores
    always_comb
    begin
        assert (!(data_write_enable && wb_write))
            else $error("store retired together with a register write");
    end

endmodule

// File: logic/register_file.sv
module register_file
(
    input  logic                    clk,
    input  logic                    reset,
    input  rv_core_pkg::reg_index_t rs1_index,
    input  rv_core_pkg::reg_index_t rs2_index,
    output rv_core_pkg::word_t      rf_data_1,
    output rv_core_pkg::word_t      rf_data_2,
    input  logic                    wb_write,
    input  rv_core_pkg::reg_index_t wb_index,
    input  rv_core_pkg::word_t      wb_data
);

    rv_core_pkg::word_t regs [2**rv_core_pkg::reg_index_bits];

    always_ff @(posedge clk)
    begin
        if (wb_write && wb_index != '0)
            regs[wb_index] <= wb_data;
    end

    // x0 is hardwired, entry 0 is never written
    assign rf_data_1 = (rs1_index == '0) ? '0 : regs[rs1_index];
    assign rf_data_2 = (rs2_index == '0) ? '0 : regs[rs2_index];

    // Writeback data travels from EX through MW and the data memory
    assert property (@(posedge clk) disable iff (reset) wb_write |-> !$isunknown(wb_data))
        else $error("register write with unknown data to x%0d", wb_index);

endmodule

// File: logic/rv_core_pkg.sv
package rv_core_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int xlen = 32;
    localparam int reg_index_bits = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_index_bits-1:0] reg_index_t;

    // First fetch address after reset, the program is placed here
    localparam word_t reset_address = 32'h1000_0000;
    // ADDI x0, x0, 0
    localparam word_t nop_word = 32'h0000_0013;

    // --------------------
    // RV32I major opcodes
    // --------------------
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;

    // ALU funct3, shared by OP and OP-IMM
    localparam logic [2:0] funct3_add  = 3'b000;
    localparam logic [2:0] funct3_sll  = 3'b001;
    localparam logic [2:0] funct3_slt  = 3'b010;
    localparam logic [2:0] funct3_sltu = 3'b011;
    localparam logic [2:0] funct3_xor  = 3'b100;
    localparam logic [2:0] funct3_srl  = 3'b101;
    localparam logic [2:0] funct3_or   = 3'b110;
    localparam logic [2:0] funct3_and  = 3'b111;

    // Branch conditions
    localparam logic [2:0] funct3_beq  = 3'b000;
    localparam logic [2:0] funct3_bne  = 3'b001;
    localparam logic [2:0] funct3_blt  = 3'b100;
    localparam logic [2:0] funct3_bge  = 3'b101;
    localparam logic [2:0] funct3_bltu = 3'b110;
    localparam logic [2:0] funct3_bgeu = 3'b111;

    // --------------------
    // Pipeline encodings
    // --------------------
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // Picks the writeback source and the memory action
    typedef enum logic [2:0] {
        class_alu, class_lui, class_auipc, class_jump_link,
        class_branch, class_load, class_store, class_bubble
    } instr_class_e;

    typedef enum logic [1:0] {from_file, from_ex, from_mw} forward_sel_e;

endpackage

// File: logic/rv_core_top.sv
module rv_core_top
(
    input  logic               clk,
    input  logic               reset,
    // Instruction memory, answers in the same cycle
    output logic               instr_enable,
    output rv_core_pkg::word_t instr_address,
    input  rv_core_pkg::word_t instr_data,
    // Data memory, answers in the same cycle
    output logic               data_read_enable,
    output logic               data_write_enable,
    output rv_core_pkg::word_t data_address,
    output rv_core_pkg::word_t data_write_data,
    input  rv_core_pkg::word_t data_read_data
);

    // Stage registers
    decoded_if decoded_bus ();
    retire_if retire_bus ();

    // Register file read side
    rv_core_pkg::reg_index_t rs1_index, rs2_index;
    logic rs1_used, rs2_used;
    rv_core_pkg::word_t rf_data_1, rf_data_2;

    // Results fed back into FD
    rv_core_pkg::word_t ex_result, redirect_target, wb_data;
    rv_core_pkg::reg_index_t wb_index;
    logic redirect, wb_write, stall;
    rv_core_pkg::forward_sel_e forward_sel_1, forward_sel_2;

    fetch_decode fetch_decode_i
    (
        .clk, .reset, .instr_enable, .instr_address, .instr_data,
        .stall, .redirect, .redirect_target, .forward_sel_1, .forward_sel_2,
        .ex_result, .wb_data, .rs1_index, .rs2_index, .rs1_used, .rs2_used,
        .rf_data_1, .rf_data_2,
        .decoded(decoded_bus)
    );

    register_file register_file_i
    (
        .clk, .reset, .rs1_index, .rs2_index, .rf_data_1, .rf_data_2,
        .wb_write, .wb_index, .wb_data
    );

    hazard_control hazard_control_i
    (
        .rs1_index, .rs2_index, .rs1_used, .rs2_used, .redirect,
        .decoded(decoded_bus),
        .wb_write, .wb_index, .stall, .forward_sel_1, .forward_sel_2
    );

    execute_unit execute_unit_i
    (
        .clk, .reset,
        .decoded(decoded_bus),
        .ex_result, .redirect, .redirect_target,
        .retired(retire_bus)
    );

    memory_writeback memory_writeback_i
    (
        .retired(retire_bus),
        .data_read_enable, .data_write_enable, .data_address, .data_write_data,
        .data_read_data, .wb_write, .wb_index, .wb_data
    );

endmodule

// File: logic/rv_stage_if.sv
// FD to EX pipeline register contents
interface decoded_if;
    rv_core_pkg::word_t pc;
    // Return address for JAL and JALR
    rv_core_pkg::word_t link_pc;
    rv_core_pkg::instr_class_e instr_class;
    rv_core_pkg::alu_op_e alu_op;
    // Register plus immediate form, also picks rs1 as the address base
    logic use_immediate;
    logic [2:0] branch_funct3;
    rv_core_pkg::word_t rs1_value, rs2_value, immediate;
    rv_core_pkg::reg_index_t rd_index;
    logic rd_write;

    modport source (output pc, link_pc, instr_class, alu_op, use_immediate, branch_funct3,
                    rs1_value, rs2_value, immediate, rd_index, rd_write);
    modport sink (input pc, link_pc, instr_class, alu_op, use_immediate, branch_funct3,
                  rs1_value, rs2_value, immediate, rd_index, rd_write);
    // Hazard logic only needs the destination of the EX instruction
    modport monitor (input instr_class, rd_index, rd_write);
endinterface

// EX to MW pipeline register contents
interface retire_if;
    rv_core_pkg::instr_class_e instr_class;
    rv_core_pkg::reg_index_t rd_index;
    logic rd_write;
    rv_core_pkg::word_t result, address, store_data;

    modport source (output instr_class, rd_index, rd_write, result, address, store_data);
    modport sink (input instr_class, rd_index, rd_write, result, address, store_data);
endinterface

// File: run_sim.sh
#!/bin/sh
# Compile and run the RV32I pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f build.f -o rv_core_sim

# The simulation status alone is not trusted, the printed result decides
output=$(./obj_dir/rv_core_sim) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"

// File: tests/program_input.txt
# T test name | I instruction word, hex, placed from the reset address
# S expected store address and data, hex, in store order
T alu_ops
I 06400093  # addi x1, x0, 100
I FF900113  # addi x2, x0, -7
I 402081B3  # sub x3, x1, x2
I 00112233  # slt x4, x2, x1
I 001132B3  # sltu x5, x2, x1
I 40115313  # srai x6, x2, 1
I 01C15393  # srli x7, x2, 28
I 00409413  # slli x8, x1, 4
I 10302023  # sw x3, 0x100(x0)
I 10402223  # sw x4, 0x104(x0)
I 10502423  # sw x5, 0x108(x0)
I 10602623  # sw x6, 0x10c(x0)
I 10702823  # sw x7, 0x110(x0)
I 10802A23  # sw x8, 0x114(x0)
S 00000100 0000006B
S 00000104 00000001
S 00000108 00000000
S 0000010C FFFFFFFC
S 00000110 0000000F
S 00000114 00000640
T forward
I 00500593  # addi x11, x0, 5
I 00358613  # addi x12, x11, 3, operand from EX
I 00C586B3  # add x13, x11, x12, operands from MW and EX
I 12D02023  # sw x13, 0x120(x0)
I 12C02223  # sw x12, 0x124(x0)
S 00000120 0000000D
S 00000124 00000008
T load_use
I 12002703  # lw x14, 0x120(x0)
I 06470793  # addi x15, x14, 100, stalls one cycle
I 12F02423  # sw x15, 0x128(x0)
I 10002803  # lw x16, 0x100(x0)
I 13002623  # sw x16, 0x12c(x0), stalls on the store data
S 00000128 00000071
S 0000012C 0000006B
T branch_jump
I 00000A13  # addi x20, x0, 0, counts fall-throughs
I 00108463  # beq x1, x1, +8, taken
I 1E002823  # sw x0, 0x1f0(x0), must be skipped
I 00109463  # bne x1, x1, +8, not taken
I 001A0A13  # addi x20, x20, 1
I 00114463  # blt x2, x1, +8, taken
I 1E002823  # sw x0, 0x1f0(x0), must be skipped
I 00115463  # bge x2, x1, +8, not taken
I 001A0A13  # addi x20, x20, 1
I 00116463  # bltu x2, x1, +8, not taken
I 001A0A13  # addi x20, x20, 1
I 00117463  # bgeu x2, x1, +8, taken
I 1E002823  # sw x0, 0x1f0(x0), must be skipped
I 00800AEF  # jal x21, +8, at 0x10000094
I 1E002823  # sw x0, 0x1f0(x0), must be skipped
I 00CA8B67  # jalr x22, 12(x21), at 0x1000009c
I 1E002823  # sw x0, 0x1f0(x0), must be skipped
I 13402823  # sw x20, 0x130(x0)
I 13502A23  # sw x21, 0x134(x0)
I 13602C23  # sw x22, 0x138(x0)
S 00000130 00000003
S 00000134 10000098
S 00000138 100000A0
T upper_imm
I 12345BB7  # lui x23, 0x12345
I 00001C17  # auipc x24, 0x1, at 0x100000b4
I 15702023  # sw x23, 0x140(x0)
I 15802223  # sw x24, 0x144(x0)
S 00000140 12345000
S 00000144 100010B4
I 0000006F  # jal x0, 0, end of program

// File: tests/rv_core_tb.sv
module rv_core_tb;

    logic clk;
    logic reset;
    logic instr_enable;
    rv_core_pkg::word_t instr_address, instr_data;
    logic data_read_enable, data_write_enable;
    rv_core_pkg::word_t data_address, data_write_data, data_read_data;

    // Program image, starts at the reset address
    rv_core_pkg::word_t program_words [$];
    // Data memory model, unwritten words read as zero
    rv_core_pkg::word_t dmem [rv_core_pkg::word_t];

    // Expected stores in program order
    rv_core_pkg::word_t expect_address [$];
    rv_core_pkg::word_t expect_data [$];
    int expect_test [$];

    // Per-test bookkeeping
    string test_names [$];
    int test_pending [$];
    int test_errors [$];

    int stray_errors = 0;
    int cycles = 0;
    int cycle_limit = 0;
    bit load_failed = 0;
    bit timed_out = 0;

    rv_core_top dut_i
    (
        .clk, .reset, .instr_enable, .instr_address, .instr_data,
        .data_read_enable, .data_write_enable, .data_address, .data_write_data,
        .data_read_data
    );

    always #50 clk = ~clk;

    // --------------------
    // Checking
    // --------------------
    task automatic compare_word(input int test_index, input string field,
                                input rv_core_pkg::word_t expected,
                                input rv_core_pkg::word_t actual);
        if (expected !== actual)
        begin
            $display("CHECK FAILED test %s %s expected %08h actual %08h",
                     test_names[test_index], field, expected, actual);
            test_errors[test_index] = test_errors[test_index] + 1;
        end
    endtask

    task automatic report_test(input int test_index);
        if (test_errors[test_index] == 0)
            $display("test %s: pass", test_names[test_index]);
        else
            $display("test %s: fail, %0d mismatches", test_names[test_index],
                     test_errors[test_index]);
    endtask

    // Matches one store on the data port against the head of the queue
    task automatic handle_store();
        int test_index;
        rv_core_pkg::word_t want_address, want_data;
        dmem[data_address] = data_write_data;
        if (expect_address.size() == 0)
        begin
            $display("Unexpected store to %08h with data %08h, no store was left to check",
                     data_address, data_write_data);
            stray_errors++;
            return;
        end
        test_index = expect_test.pop_front();
        want_address = expect_address.pop_front();
        want_data = expect_data.pop_front();
        compare_word(test_index, "store address", want_address, data_address);
        compare_word(test_index, "store data", want_data, data_write_data);
        test_pending[test_index] = test_pending[test_index] - 1;
        if (test_pending[test_index] == 0)
            report_test(test_index);
    endtask

    // --------------------
    // Memory models
    // --------------------
    function automatic rv_core_pkg::word_t fetch_word(input rv_core_pkg::word_t address);
        rv_core_pkg::word_t offset;
        offset = address - rv_core_pkg::reset_address;
        // Outside the program the core only sees NOPs
        if (address < rv_core_pkg::reset_address || offset[1:0] != 2'b00
            || (offset >> 2) >= program_words.size())
            return rv_core_pkg::nop_word;
        return program_words[offset >> 2];
    endfunction

    function automatic rv_core_pkg::word_t read_word(input rv_core_pkg::word_t address);
        if (dmem.exists(address))
            return dmem[address];
        return '0;
    endfunction

    // Outputs settle after the rising edge, so both memories answer here
    always @(negedge clk)
    begin
        if (reset)
        begin
            if (data_write_enable === 1'b1)
            begin
                $display("Store to %08h issued while reset is high", data_address);
                stray_errors++;
            end
            if (instr_enable === 1'b1)
            begin
                $display("Instruction fetch enabled while reset is high");
                stray_errors++;
            end
        end
        else if (data_write_enable === 1'b1)
        begin
            handle_store();
        end
        instr_data = fetch_word(instr_address);
        data_read_data = (data_read_enable === 1'b1) ? read_word(data_address) : '0;
    end

    // --------------------
    // Program file
    // --------------------
    // Records are T name, I word, S address data, and # starts a comment
    task automatic load_program();
        int fd, code, current;
        string kind, name, rest;
        rv_core_pkg::word_t first, second;
        current = -1;
        fd = $fopen("tests/program_input.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open tests/program_input.txt");
            load_failed = 1;
            return;
        end
        while (!$feof(fd))
        begin
            code = $fscanf(fd, "%s", kind);
            if (code == 1)
            begin
                if (kind == "T")
                begin
                    code = $fscanf(fd, "%s", name);
                    test_names.push_back(name);
                    test_pending.push_back(0);
                    test_errors.push_back(0);
                    current = test_names.size() - 1;
                end
                else if (kind == "I")
                begin
                    code = $fscanf(fd, "%h", first);
                    program_words.push_back(first);
                end
                else if (kind == "S" && current >= 0)
                begin
                    code = $fscanf(fd, "%h %h", first, second);
                    expect_address.push_back(first);
                    expect_data.push_back(second);
                    expect_test.push_back(current);
                    test_pending[current] = test_pending[current] + 1;
                end
                else if (kind != "#")
                begin
                    $display("Bad record %s in tests/program_input.txt", kind);
                    load_failed = 1;
                end
                // Rest of the line is a remark
                code = $fgets(rest, fd);
            end
        end
        $fclose(fd);
        if (program_words.size() == 0 || expect_address.size() == 0)
        begin
            $display("tests/program_input.txt holds no program or no expected stores");
            load_failed = 1;
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        int passed, failed;
        clk = 1'b0;
        reset = 1'b1;
        instr_data = rv_core_pkg::nop_word;
        data_read_data = '0;
        passed = 0;
        failed = 0;
        load_program();
        if (!load_failed)
        begin
            cycle_limit = 20 * program_words.size() + 100;
            repeat (5) @(posedge clk);
            @(negedge clk);
            reset <= 1'b0;
            // Runs until every expected store has been seen
            while (expect_address.size() > 0 && cycles < cycle_limit)
            begin
                @(posedge clk);
                cycles++;
            end
            if (expect_address.size() > 0)
            begin
                timed_out = 1;
                foreach (test_names[i])
                begin
                    if (test_pending[i] > 0)
                        $display("Timeout after %0d cycles, test %s never finished",
                                 cycles, test_names[i]);
                end
            end
            else
            begin
                // The program spins on its last JAL, any late store is stray
                repeat (10) @(posedge clk);
            end
        end
        foreach (test_names[i])
        begin
            if (test_pending[i] == 0 && test_errors[i] == 0)
                passed++;
            else
                failed++;
        end
        $display("Tests passed: %0d, failed: %0d, other errors: %0d",
                 passed, failed, stray_errors);
        if (failed == 0 && stray_errors == 0 && !load_failed && !timed_out)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
